//--- Bender.yml
package:
  name: rv_decode

sources:
  - source/rv_decode_pkg.sv
  - source/decode_bus_if.sv
  - source/rv_insn_decoder.sv
  - source/rv_imm_select.sv
  - source/decode_handshake_fsm.sv
  - source/insn_counter.sv
  - source/rv_decode_top.sv
  - target: test
    files:
      - testbench/decode_checker.sv
      - testbench/tb_rv_decode.sv

//--- source/decode_bus_if.sv
// Decoded record bus between the instruction decoder and the immediate selector
`timescale 1ns/100ps

interface decode_bus_if;

    rv_decode_pkg::op_class_t op_class;
    rv_decode_pkg::reg_idx_t  rd;
    rv_decode_pkg::reg_idx_t  rs1;
    rv_decode_pkg::reg_idx_t  rs2;
    rv_decode_pkg::reg_idx_t  rs3;
    rv_decode_pkg::rm_t       rm;
    rv_decode_pkg::imm_t      imm_i;
    rv_decode_pkg::imm_t      imm_s;
    rv_decode_pkg::imm_t      imm_b;
    rv_decode_pkg::imm_t      imm_u;
    rv_decode_pkg::imm_t      imm_j;

    modport producer (
        output op_class, rd, rs1, rs2, rs3, rm, imm_i, imm_s, imm_b, imm_u, imm_j
    );

    modport consumer (
        input op_class, rd, rs1, rs2, rs3, rm, imm_i, imm_s, imm_b, imm_u, imm_j
    );

endinterface

//--- source/decode_handshake_fsm.sv
// FSM for the four-phase input and output handshakes and the data register strobes
`timescale 1ns/100ps

module decode_handshake_fsm (
    input  logic  clock,
    input  logic  rst_n,
    input  logic  in_req,
    output logic  in_ack,
    output logic  out_req,
    input  logic  out_ack,
    output logic  capture,
    output logic  load,
    output logic  delivered
);

    rv_decode_pkg::decode_state_t  state;
    rv_decode_pkg::decode_state_t  next_state;

    // Strobes are decoded from the state so they line up with the transition edge
    assign capture   = (state == rv_decode_pkg::st_idle) && in_req;
    assign load      = (state == rv_decode_pkg::st_decode);
    assign delivered = (state == rv_decode_pkg::st_present) && out_ack;

    always_comb begin
        next_state = state;
        case (state)
            rv_decode_pkg::st_idle: begin
                if (in_req) next_state = rv_decode_pkg::st_decode;
            end
            rv_decode_pkg::st_decode:  next_state = rv_decode_pkg::st_select;
            rv_decode_pkg::st_select:  next_state = rv_decode_pkg::st_present;
            rv_decode_pkg::st_present: begin
                if (out_ack) next_state = rv_decode_pkg::st_release; // Sink took the record
            end
            rv_decode_pkg::st_release: begin
                if (!out_ack && !in_req) next_state = rv_decode_pkg::st_idle;
            end
            default: next_state = rv_decode_pkg::st_idle;
        endcase
    end

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            state   <= rv_decode_pkg::st_idle;
            in_ack  <= 1'b0;
            out_req <= 1'b0;
        end else begin
            state <= next_state;
            case (state)
                rv_decode_pkg::st_select: begin
                    in_ack  <= 1'b1;
                    out_req <= 1'b1;
                end
                rv_decode_pkg::st_present: begin
                    if (out_ack) out_req <= 1'b0;
                end
                rv_decode_pkg::st_release: begin
                    if (!out_ack && !in_req) in_ack <= 1'b0; // Both partners have let go
                end
                default: ;
            endcase
        end
    end

endmodule

//--- source/insn_counter.sv
// Delivered and illegal instruction counters
`timescale 1ns/100ps

module insn_counter (
    input  logic                      clock,
    input  logic                      rst_n,
    input  logic                      delivered,
    input  rv_decode_pkg::op_class_t  op_class,
    output rv_decode_pkg::count_t     insn_count,
    output rv_decode_pkg::count_t     illegal_count
);

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            insn_count    <= '0;
            illegal_count <= '0;
        end else if (delivered) begin
            insn_count <= insn_count + 16'd1; // Wraps at 16 bits
            if (op_class == rv_decode_pkg::op_illegal) begin
                illegal_count <= illegal_count + 16'd1;
            end
        end
    end

endmodule

//--- source/rv_decode_pkg.sv
// Decode types, opcode and funct5 constants, operation classes and handshake states
package rv_decode_pkg;

    typedef logic [31:0] insn_t;
    typedef logic [4:0]  reg_idx_t;
    typedef logic [31:0] imm_t;
    typedef logic [2:0]  rm_t;
    typedef logic [15:0] count_t;

    typedef enum logic [4:0] {
        op_branch, op_alu_imm, op_alu_reg, op_jal, op_jalr,
        op_lui, op_auipc, op_load, op_store, op_system,
        op_fadd, op_fsub, op_fmul, op_fdiv, op_fsgnj, op_fminmax,
        op_fsqrt, op_fcmp, op_fcvt_f2i, op_fmv_f2i, op_fcvt_i2f, op_fmv_i2f,
        op_flw, op_fsw, op_fmadd, op_fmsub, op_fnmsub, op_fnmadd,
        op_illegal
    } op_class_t;

    // Release is a keyword, so every state carries a prefix
    typedef enum logic [2:0] {
        st_idle, st_decode, st_select, st_present, st_release
    } decode_state_t;

    localparam logic [6:0] opc_load    = 7'h03;
    localparam logic [6:0] opc_flw     = 7'h07;
    localparam logic [6:0] opc_alu_imm = 7'h13;
    localparam logic [6:0] opc_auipc   = 7'h17;
    localparam logic [6:0] opc_store   = 7'h23;
    localparam logic [6:0] opc_fsw     = 7'h27;
    localparam logic [6:0] opc_alu_reg = 7'h33;
    localparam logic [6:0] opc_lui     = 7'h37;
    localparam logic [6:0] opc_fmadd   = 7'h43;
    localparam logic [6:0] opc_fmsub   = 7'h47;
    localparam logic [6:0] opc_fnmsub  = 7'h4b;
    localparam logic [6:0] opc_fnmadd  = 7'h4f;
    localparam logic [6:0] opc_op_fp   = 7'h53;
    localparam logic [6:0] opc_branch  = 7'h63;
    localparam logic [6:0] opc_jalr    = 7'h67;
    localparam logic [6:0] opc_jal     = 7'h6f;
    localparam logic [6:0] opc_system  = 7'h73;

    localparam logic [4:0] f5_fadd     = 5'h00;
    localparam logic [4:0] f5_fsub     = 5'h01;
    localparam logic [4:0] f5_fmul     = 5'h02;
    localparam logic [4:0] f5_fdiv     = 5'h03;
    localparam logic [4:0] f5_fsgnj    = 5'h04;
    localparam logic [4:0] f5_fminmax  = 5'h05;
    localparam logic [4:0] f5_fsqrt    = 5'h0b;
    localparam logic [4:0] f5_fcmp     = 5'h14;
    localparam logic [4:0] f5_fcvt_f2i = 5'h18;
    localparam logic [4:0] f5_fmv_f2i  = 5'h1c;
    localparam logic [4:0] f5_fcvt_i2f = 5'h1a;
    localparam logic [4:0] f5_fmv_i2f  = 5'h1e;

endpackage

//--- source/rv_decode_top.sv
// Top level of the instruction decode unit with plain handshake and record ports
`timescale 1ns/100ps

module rv_decode_top (
    input  logic                      clock,
    input  logic                      rst_n,
    input  logic                      in_req,
    output logic                      in_ack,
    input  rv_decode_pkg::insn_t      insn,
    output logic                      out_req,
    input  logic                      out_ack,
    output rv_decode_pkg::op_class_t  op_class,
    output logic                      illegal,
    output rv_decode_pkg::reg_idx_t   rd,
    output rv_decode_pkg::reg_idx_t   rs1,
    output rv_decode_pkg::reg_idx_t   rs2,
    output rv_decode_pkg::reg_idx_t   rs3,
    output rv_decode_pkg::rm_t        rm,
    output rv_decode_pkg::imm_t       imm,
    output rv_decode_pkg::count_t     insn_count,
    output rv_decode_pkg::count_t     illegal_count
);

    logic  capture;
    logic  load;
    logic  delivered;

    decode_bus_if dec_bus ();

    decode_handshake_fsm u_fsm (
        .clock     (clock),
        .rst_n     (rst_n),
        .in_req    (in_req),
        .in_ack    (in_ack),
        .out_req   (out_req),
        .out_ack   (out_ack),
        .capture   (capture),
        .load      (load),
        .delivered (delivered)
    );

    rv_insn_decoder u_decoder (
        .clock   (clock),
        .rst_n   (rst_n),
        .capture (capture),
        .insn    (insn),
        .dec     (dec_bus.producer)
    );

    rv_imm_select u_imm_select (
        .clock    (clock),
        .rst_n    (rst_n),
        .load     (load),
        .dec      (dec_bus.consumer),
        .op_class (op_class),
        .rd       (rd),
        .rs1      (rs1),
        .rs2      (rs2),
        .rs3      (rs3),
        .rm       (rm),
        .imm      (imm)
    );

    insn_counter u_counter (
        .clock         (clock),
        .rst_n         (rst_n),
        .delivered     (delivered),
        .op_class      (op_class),
        .insn_count    (insn_count),
        .illegal_count (illegal_count)
    );

    assign illegal = (op_class == rv_decode_pkg::op_illegal);

endmodule

//--- source/rv_imm_select.sv
// Output record register that keeps only the immediate the instruction format uses
`timescale 1ns/100ps

module rv_imm_select (
    input  logic                      clock,
    input  logic                      rst_n,
    input  logic                      load,
    decode_bus_if.consumer            dec,
    output rv_decode_pkg::op_class_t  op_class,
    output rv_decode_pkg::reg_idx_t   rd,
    output rv_decode_pkg::reg_idx_t   rs1,
    output rv_decode_pkg::reg_idx_t   rs2,
    output rv_decode_pkg::reg_idx_t   rs3,
    output rv_decode_pkg::rm_t        rm,
    output rv_decode_pkg::imm_t       imm
);

    rv_decode_pkg::imm_t  imm_sel;

    always_comb begin
        case (dec.op_class)
            rv_decode_pkg::op_alu_imm, rv_decode_pkg::op_load,
            rv_decode_pkg::op_jalr, rv_decode_pkg::op_flw:  imm_sel = dec.imm_i;
            rv_decode_pkg::op_store, rv_decode_pkg::op_fsw: imm_sel = dec.imm_s;
            rv_decode_pkg::op_branch:                       imm_sel = dec.imm_b;
            rv_decode_pkg::op_lui, rv_decode_pkg::op_auipc: imm_sel = dec.imm_u;
            rv_decode_pkg::op_jal:                          imm_sel = dec.imm_j;
            default:                                        imm_sel = '0; // No immediate
        endcase
    end

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            op_class <= rv_decode_pkg::op_illegal;
        end else if (load) begin
            op_class <= dec.op_class;
        end
    end

    always_ff @(posedge clock) begin
        if (load) begin
            rd  <= dec.rd;
            rs1 <= dec.rs1;
            rs2 <= dec.rs2;
            rs3 <= dec.rs3;
            rm  <= dec.rm;
            imm <= imm_sel;
        end
    end

endmodule

//--- source/rv_insn_decoder.sv
// Registered RV32IMF decoder producing class, register fields and all immediate forms
`timescale 1ns/100ps

module rv_insn_decoder (
    input  logic                  clock,
    input  logic                  rst_n,
    input  logic                  capture,
    input  rv_decode_pkg::insn_t  insn,
    decode_bus_if.producer        dec
);

    logic [6:0]                opcode;
    logic [4:0]                funct5;
    rv_decode_pkg::op_class_t  next_class;

    assign opcode = insn[6:0];
    assign funct5 = insn[31:27];

    always_comb begin
        case (opcode)
            rv_decode_pkg::opc_branch:  next_class = rv_decode_pkg::op_branch;
            rv_decode_pkg::opc_alu_imm: next_class = rv_decode_pkg::op_alu_imm;
            rv_decode_pkg::opc_alu_reg: next_class = rv_decode_pkg::op_alu_reg; // M shares this
            rv_decode_pkg::opc_jal:     next_class = rv_decode_pkg::op_jal;
            rv_decode_pkg::opc_jalr:    next_class = rv_decode_pkg::op_jalr;
            rv_decode_pkg::opc_lui:     next_class = rv_decode_pkg::op_lui;
            rv_decode_pkg::opc_auipc:   next_class = rv_decode_pkg::op_auipc;
            rv_decode_pkg::opc_load:    next_class = rv_decode_pkg::op_load;
            rv_decode_pkg::opc_store:   next_class = rv_decode_pkg::op_store;
            rv_decode_pkg::opc_system:  next_class = rv_decode_pkg::op_system;
            rv_decode_pkg::opc_flw:     next_class = rv_decode_pkg::op_flw;
            rv_decode_pkg::opc_fsw:     next_class = rv_decode_pkg::op_fsw;
            rv_decode_pkg::opc_fmadd:   next_class = rv_decode_pkg::op_fmadd;
            rv_decode_pkg::opc_fmsub:   next_class = rv_decode_pkg::op_fmsub;
            rv_decode_pkg::opc_fnmsub:  next_class = rv_decode_pkg::op_fnmsub;
            rv_decode_pkg::opc_fnmadd:  next_class = rv_decode_pkg::op_fnmadd;
            rv_decode_pkg::opc_op_fp: begin
                // OP-FP is split further by funct5 in the top bits
                case (funct5)
                    rv_decode_pkg::f5_fadd:     next_class = rv_decode_pkg::op_fadd;
                    rv_decode_pkg::f5_fsub:     next_class = rv_decode_pkg::op_fsub;
                    rv_decode_pkg::f5_fmul:     next_class = rv_decode_pkg::op_fmul;
                    rv_decode_pkg::f5_fdiv:     next_class = rv_decode_pkg::op_fdiv;
                    rv_decode_pkg::f5_fsgnj:    next_class = rv_decode_pkg::op_fsgnj;
                    rv_decode_pkg::f5_fminmax:  next_class = rv_decode_pkg::op_fminmax;
                    rv_decode_pkg::f5_fsqrt:    next_class = rv_decode_pkg::op_fsqrt;
                    rv_decode_pkg::f5_fcmp:     next_class = rv_decode_pkg::op_fcmp;
                    rv_decode_pkg::f5_fcvt_f2i: next_class = rv_decode_pkg::op_fcvt_f2i;
                    rv_decode_pkg::f5_fmv_f2i:  next_class = rv_decode_pkg::op_fmv_f2i;
                    rv_decode_pkg::f5_fcvt_i2f: next_class = rv_decode_pkg::op_fcvt_i2f;
                    rv_decode_pkg::f5_fmv_i2f:  next_class = rv_decode_pkg::op_fmv_i2f;
                    default:                    next_class = rv_decode_pkg::op_illegal;
                endcase
            end
            default: next_class = rv_decode_pkg::op_illegal;
        endcase
    end

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            dec.op_class <= rv_decode_pkg::op_illegal;
        end else if (capture) begin
            dec.op_class <= next_class;
        end
    end

    // Field extraction is the same for every format
    always_ff @(posedge clock) begin
        if (capture) begin
            dec.rd  <= insn[11:7];
            dec.rs1 <= insn[19:15];
            dec.rs2 <= insn[24:20];
            dec.rs3 <= insn[31:27];
            dec.rm  <= insn[14:12];

            // All immediates sign extend from bit 31
            dec.imm_i <= {{20{insn[31]}}, insn[31:20]};
            dec.imm_s <= {{20{insn[31]}}, insn[31:25], insn[11:7]};
            dec.imm_b <= {{19{insn[31]}}, insn[31], insn[7], insn[30:25], insn[11:8], 1'b0};
            dec.imm_u <= {insn[31:12], 12'b0};
            dec.imm_j <= {{11{insn[31]}}, insn[31], insn[19:12], insn[20], insn[30:21], 1'b0};
        end
    end

endmodule

//--- src.f
source/rv_decode_pkg.sv
source/decode_bus_if.sv
source/rv_insn_decoder.sv
source/rv_imm_select.sv
source/decode_handshake_fsm.sv
source/insn_counter.sv
source/rv_decode_top.sv
testbench/decode_checker.sv
testbench/tb_rv_decode.sv

//--- testbench/decode_checker.sv
// Monitor that compares delivered records, handshake timing and final counts
`timescale 1ns/100ps

module decode_checker (
    input  logic                      clock,
    input  logic                      in_req,
    input  logic                      out_req,
    input  logic                      out_ack,
    input  rv_decode_pkg::op_class_t  op_class,
    input  logic                      illegal,
    input  rv_decode_pkg::reg_idx_t   rd,
    input  rv_decode_pkg::reg_idx_t   rs1,
    input  rv_decode_pkg::reg_idx_t   rs2,
    input  rv_decode_pkg::reg_idx_t   rs3,
    input  rv_decode_pkg::rm_t        rm,
    input  rv_decode_pkg::imm_t       imm,
    input  rv_decode_pkg::count_t     insn_count,
    input  rv_decode_pkg::count_t     illegal_count,
    input  int                        exp_index,
    input  rv_decode_pkg::insn_t      exp_insn,
    input  rv_decode_pkg::op_class_t  exp_class,
    input  rv_decode_pkg::reg_idx_t   exp_rd,
    input  rv_decode_pkg::reg_idx_t   exp_rs1,
    input  rv_decode_pkg::reg_idx_t   exp_rs2,
    input  rv_decode_pkg::imm_t       exp_imm,
    input  int                        n_entries,
    input  int                        n_illegal,
    input  logic                      done,
    output int                        error_count
);

    localparam time clock_period = 40;

    time   req_time;
    logic  req_seen;
    int    deliveries;
    int    test_errors;

    initial begin
        error_count = 0;
        deliveries  = 0;
        req_seen    = 1'b0;
        req_time    = 0;
    end

    // Edge at which in_req is first sampled high
    always @(posedge clock) begin
        if (!in_req) begin
            req_seen <= 1'b0;
        end else if (!req_seen) begin
            req_seen <= 1'b1;
            req_time <= $time;
        end
    end

    task automatic check_field(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (expected !== actual) begin
            $display("FAILED t=%0t %s expected 0x%08h got 0x%08h", $time, name, expected, actual);
            test_errors++;
        end
    endtask

    always @(posedge out_req) begin
        test_errors = 0;
        if (out_ack) begin
            $display("out_req rose while out_ack was still high in test %0d", deliveries);
            test_errors++;
        end
        if (deliveries != exp_index) begin
            $display("Record %0d arrived while test %0d was being applied", deliveries, exp_index);
            test_errors++;
        end
        // Capture, load and select take the sampling edge and the two edges after it
        if ($time - req_time != 2 * clock_period) begin
            $display("out_req rose %0t after in_req was sampled instead of two cycles",
                     $time - req_time);
            test_errors++;
        end
        check_field("op_class", 32'(exp_class), 32'(op_class));
        check_field("illegal", 32'(exp_class == rv_decode_pkg::op_illegal), 32'(illegal));
        check_field("rd", 32'(exp_rd), 32'(rd));
        check_field("rs1", 32'(exp_rs1), 32'(rs1));
        check_field("rs2", 32'(exp_rs2), 32'(rs2));
        check_field("rs3", 32'(exp_insn[31:27]), 32'(rs3));
        check_field("rm", 32'(exp_insn[14:12]), 32'(rm));
        check_field("imm", exp_imm, imm);
        $display("Test %0d insn 0x%08h %s", deliveries, exp_insn,
                 (test_errors == 0) ? "passed" : "failed");
        error_count += test_errors;
        deliveries++;
    end

    always @(posedge done) begin
        test_errors = 0;
        if (deliveries != n_entries) begin
            $display("Only %0d of %0d records were delivered", deliveries, n_entries);
            test_errors++;
        end
        check_field("insn_count", 32'(n_entries), 32'(insn_count));
        check_field("illegal_count", 32'(n_illegal), 32'(illegal_count));
        error_count += test_errors;
        $display("Tests %0d, errors %0d, insn_count %0d, illegal_count %0d",
                 deliveries, error_count, insn_count, illegal_count);
    end

endmodule

//--- testbench/tb_rv_decode.sv
// Testbench top with clock, reset, stimulus table, input source and output sink drivers
`timescale 1ns/100ps

module tb_rv_decode;

    localparam int max_entries = 64;
    localparam int wait_limit  = 100;

    logic                      clock;
    logic                      rst_n;
    logic                      in_req;
    logic                      in_ack;
    rv_decode_pkg::insn_t      insn;
    logic                      out_req;
    logic                      out_ack;
    rv_decode_pkg::op_class_t  op_class;
    logic                      illegal;
    rv_decode_pkg::reg_idx_t   rd;
    rv_decode_pkg::reg_idx_t   rs1;
    rv_decode_pkg::reg_idx_t   rs2;
    rv_decode_pkg::reg_idx_t   rs3;
    rv_decode_pkg::rm_t        rm;
    rv_decode_pkg::imm_t       imm;
    rv_decode_pkg::count_t     insn_count;
    rv_decode_pkg::count_t     illegal_count;

    rv_decode_pkg::insn_t      tbl_insn [max_entries];
    rv_decode_pkg::op_class_t  tbl_class [max_entries];
    rv_decode_pkg::reg_idx_t   tbl_rd [max_entries];
    rv_decode_pkg::reg_idx_t   tbl_rs1 [max_entries];
    rv_decode_pkg::reg_idx_t   tbl_rs2 [max_entries];
    rv_decode_pkg::imm_t       tbl_imm [max_entries];

    int                        n_entries;
    int                        n_illegal;
    int                        cur_index;
    rv_decode_pkg::insn_t      exp_insn;
    rv_decode_pkg::op_class_t  exp_class;
    rv_decode_pkg::reg_idx_t   exp_rd;
    rv_decode_pkg::reg_idx_t   exp_rs1;
    rv_decode_pkg::reg_idx_t   exp_rs2;
    rv_decode_pkg::imm_t       exp_imm;
    logic                      done;
    int                        error_count;
    logic [31:0]               lcg_state;

    rv_decode_top u_rv_decode_top (
        .clock(clock), .rst_n(rst_n), .in_req(in_req), .in_ack(in_ack), .insn(insn),
        .out_req(out_req), .out_ack(out_ack), .op_class(op_class), .illegal(illegal),
        .rd(rd), .rs1(rs1), .rs2(rs2), .rs3(rs3), .rm(rm), .imm(imm),
        .insn_count(insn_count), .illegal_count(illegal_count)
    );

    decode_checker u_checker (
        .clock(clock), .in_req(in_req), .out_req(out_req), .out_ack(out_ack),
        .op_class(op_class), .illegal(illegal), .rd(rd), .rs1(rs1), .rs2(rs2), .rs3(rs3),
        .rm(rm), .imm(imm), .insn_count(insn_count), .illegal_count(illegal_count),
        .exp_index(cur_index), .exp_insn(exp_insn), .exp_class(exp_class), .exp_rd(exp_rd),
        .exp_rs1(exp_rs1), .exp_rs2(exp_rs2), .exp_imm(exp_imm), .n_entries(n_entries),
        .n_illegal(n_illegal), .done(done), .error_count(error_count)
    );

    always #20 clock = ~clock;

    function automatic logic [31:0] next_rand();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    // Instruction encoders, one per RISC-V format
    function automatic logic [31:0] enc_r(logic [6:0] f7, logic [4:0] s2, logic [4:0] s1,
                                          logic [2:0] f3, logic [4:0] d, logic [6:0] opc);
        return {f7, s2, s1, f3, d, opc};
    endfunction

    function automatic logic [31:0] enc_i(logic [11:0] im, logic [4:0] s1, logic [2:0] f3,
                                          logic [4:0] d, logic [6:0] opc);
        return {im, s1, f3, d, opc};
    endfunction

    function automatic logic [31:0] enc_s(logic [11:0] im, logic [4:0] s2, logic [4:0] s1,
                                          logic [2:0] f3, logic [6:0] opc);
        return {im[11:5], s2, s1, f3, im[4:0], opc};
    endfunction

    function automatic logic [31:0] enc_b(logic [12:0] im, logic [4:0] s2, logic [4:0] s1,
                                          logic [2:0] f3);
        return {im[12], im[10:5], s2, s1, f3, im[4:1], im[11], rv_decode_pkg::opc_branch};
    endfunction

    function automatic logic [31:0] enc_j(logic [20:0] im, logic [4:0] d);
        return {im[20], im[10:1], im[11], im[19:12], d, rv_decode_pkg::opc_jal};
    endfunction

    // Register fields sit at fixed bit positions in every format
    task automatic add_entry(input rv_decode_pkg::insn_t word,
                             input rv_decode_pkg::op_class_t cls, input rv_decode_pkg::imm_t im);
        tbl_insn[n_entries]  = word;
        tbl_class[n_entries] = cls;
        tbl_rd[n_entries]    = word[11:7];
        tbl_rs1[n_entries]   = word[19:15];
        tbl_rs2[n_entries]   = word[24:20];
        tbl_imm[n_entries]   = im;
        if (cls == rv_decode_pkg::op_illegal) n_illegal++;
        n_entries++;
    endtask

    task automatic fill_table();
        logic [4:0]                fp_f5 [12];
        rv_decode_pkg::op_class_t  fp_cls [12];
        logic [6:0]                fused_opc [4];
        rv_decode_pkg::op_class_t  fused_cls [4];
        fp_f5  = '{5'h00, 5'h01, 5'h02, 5'h03, 5'h04, 5'h05,
                   5'h0b, 5'h14, 5'h18, 5'h1c, 5'h1a, 5'h1e};
        fp_cls = '{rv_decode_pkg::op_fadd, rv_decode_pkg::op_fsub, rv_decode_pkg::op_fmul,
                   rv_decode_pkg::op_fdiv, rv_decode_pkg::op_fsgnj, rv_decode_pkg::op_fminmax,
                   rv_decode_pkg::op_fsqrt, rv_decode_pkg::op_fcmp, rv_decode_pkg::op_fcvt_f2i,
                   rv_decode_pkg::op_fmv_f2i, rv_decode_pkg::op_fcvt_i2f,
                   rv_decode_pkg::op_fmv_i2f};
        fused_opc = '{7'h43, 7'h47, 7'h4b, 7'h4f};
        fused_cls = '{rv_decode_pkg::op_fmadd, rv_decode_pkg::op_fmsub,
                      rv_decode_pkg::op_fnmsub, rv_decode_pkg::op_fnmadd};
        add_entry(enc_b(13'h1ff0, 5'd5, 5'd6, 3'd1), rv_decode_pkg::op_branch, 32'hfffffff0);
        add_entry(enc_b(13'h0808, 5'd7, 5'd8, 3'd0), rv_decode_pkg::op_branch, 32'h00000808);
        add_entry(enc_i(12'hffb, 5'd3, 3'd0, 5'd4, 7'h13), rv_decode_pkg::op_alu_imm,
                  32'hfffffffb);
        add_entry(enc_i(12'h7ff, 5'd31, 3'd6, 5'd30, 7'h13), rv_decode_pkg::op_alu_imm,
                  32'h000007ff);
        add_entry(enc_r(7'h01, 5'd9, 5'd8, 3'd0, 5'd7, 7'h33), rv_decode_pkg::op_alu_reg, 32'h0);
        add_entry(enc_j(21'h1ffffc, 5'd1), rv_decode_pkg::op_jal, 32'hfffffffc);
        add_entry(enc_j(21'h012344, 5'd2), rv_decode_pkg::op_jal, 32'h00012344);
        add_entry(enc_i(12'h800, 5'd1, 3'd0, 5'd0, 7'h67), rv_decode_pkg::op_jalr, 32'hfffff800);
        add_entry({20'hdeadb, 5'd10, 7'h37}, rv_decode_pkg::op_lui, 32'hdeadb000);
        add_entry({20'h00012, 5'd11, 7'h17}, rv_decode_pkg::op_auipc, 32'h00012000);
        add_entry(enc_i(12'h010, 5'd2, 3'd2, 5'd12, 7'h03), rv_decode_pkg::op_load, 32'h10);
        add_entry(enc_s(12'hff8, 5'd13, 5'd2, 3'd2, 7'h23), rv_decode_pkg::op_store,
                  32'hfffffff8);
        add_entry(enc_s(12'h123, 5'd14, 5'd3, 3'd1, 7'h23), rv_decode_pkg::op_store, 32'h123);
        add_entry(enc_i(12'h001, 5'd0, 3'd0, 5'd0, 7'h73), rv_decode_pkg::op_system, 32'h0);
        for (int k = 0; k < 12; k++) begin
            add_entry(enc_r({fp_f5[k], 2'b00}, 5'(k + 1), 5'(k + 2), 3'(k), 5'(k + 3), 7'h53),
                      fp_cls[k], 32'h0);
        end
        add_entry(enc_i(12'hffc, 5'd2, 3'd2, 5'd15, 7'h07), rv_decode_pkg::op_flw, 32'hfffffffc);
        add_entry(enc_s(12'h044, 5'd16, 5'd2, 3'd2, 7'h27), rv_decode_pkg::op_fsw, 32'h44);
        for (int k = 0; k < 4; k++) begin
            add_entry(enc_r({5'(k + 17), 2'b00}, 5'(k + 4), 5'(k + 5), 3'(k + 1), 5'(k + 6),
                            fused_opc[k]), fused_cls[k], 32'h0);
        end
        add_entry(32'hfffff07f, rv_decode_pkg::op_illegal, 32'h0); // Unknown opcode
        add_entry(enc_r(7'h7c, 5'd1, 5'd2, 3'd0, 5'd3, 7'h53), rv_decode_pkg::op_illegal, 32'h0);
        add_entry(32'h00000000, rv_decode_pkg::op_illegal, 32'h0);
    endtask

    task automatic wait_signal(input bit use_out_req, input logic level, input string what);
        int    cycles;
        logic  value;
        cycles = 0;
        value  = ~level;
        while (value !== level) begin
            @(posedge clock);
            value = use_out_req ? out_req : in_ack;
            cycles++;
            if (value !== level && cycles >= wait_limit) begin
                $display("Timeout after %0d cycles waiting for %s in test %0d",
                         wait_limit, what, cur_index);
                $display("Something failed");
                $finish;
            end
        end
    endtask

    task automatic drive_source(input rv_decode_pkg::insn_t word);
        @(posedge clock);
        insn   <= word;
        in_req <= 1'b1;
        wait_signal(1'b0, 1'b1, "in_ack high");
        in_req <= 1'b0;
        wait_signal(1'b0, 1'b0, "in_ack low");
    endtask

    task automatic answer_sink();
        int delay;
        wait_signal(1'b1, 1'b1, "out_req high");
        delay = (next_rand() >> 16) % 6; // Back-pressure of 0 to 5 cycles
        repeat (delay) @(posedge clock);
        out_ack <= 1'b1;
        wait_signal(1'b1, 1'b0, "out_req low");
        out_ack <= 1'b0;
    endtask

    initial begin
        clock     = 1'b0;
        rst_n     = 1'b0;
        in_req    = 1'b0;
        out_ack   = 1'b0;
        insn      = '0;
        done      = 1'b0;
        cur_index = 0;
        n_entries = 0;
        n_illegal = 0;
        lcg_state = 32'hd7381266;
        fill_table();
        exp_insn  = tbl_insn[0];
        exp_class = tbl_class[0];
        exp_rd    = tbl_rd[0];
        exp_rs1   = tbl_rs1[0];
        exp_rs2   = tbl_rs2[0];
        exp_imm   = tbl_imm[0];
        repeat (8) @(posedge clock);
        rst_n <= 1'b1;
        for (int i = 0; i < n_entries; i++) begin
            cur_index = i;
            exp_insn  = tbl_insn[i];
            exp_class = tbl_class[i];
            exp_rd    = tbl_rd[i];
            exp_rs1   = tbl_rs1[i];
            exp_rs2   = tbl_rs2[i];
            exp_imm   = tbl_imm[i];
            fork
                drive_source(tbl_insn[i]);
                answer_sink();
            join
        end
        @(posedge clock);
        done <= 1'b1;
        repeat (2) @(posedge clock);
        if (error_count == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule
